/* compile.f */
+incdir+design
design/cost_types_pkg.sv
design/cost_ctrl_pkg.sv
design/cost_ctrl_fsm.sv
design/seq_counter.sv
design/block_buffer.sv
design/weight_table.sv
design/hadamard_cost.sv
design/best_tracker.sv
design/cost_engine_top.sv
dv/cost_engine_properties.sv
dv/cost_engine_tb.sv

/* design/best_tracker.sv */
// Minimum cost tracker
`timescale 1ns/1ps

module best_tracker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      best_update_i,
    input  logic                      best_clear_i,
    input  cost_types_pkg::cost_t     calc_cost_i,
    input  cost_types_pkg::cand_idx_t cand_idx_i,
    output cost_types_pkg::cost_t     best_cost_o,
    output cost_types_pkg::cand_idx_t best_idx_o
);

    cost_types_pkg::cost_t     best_cost_q;
    cost_types_pkg::cand_idx_t best_idx_q;
    // Set once the first candidate has loaded
    logic                      valid_q;
    logic                      take_new;

    // Strictly smaller wins, so ties keep the earlier index
    assign take_new = !valid_q || (calc_cost_i < best_cost_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best_cost_q <= '0;
            best_idx_q  <= '0;
            valid_q     <= 1'b0;
        end else if (best_clear_i) begin
            best_cost_q <= '0;
            best_idx_q  <= '0;
            valid_q     <= 1'b0;
        end else if (best_update_i && take_new) begin
            best_cost_q <= calc_cost_i;
            best_idx_q  <= cand_idx_i;
            valid_q     <= 1'b1;
        end
    end

    assign best_cost_o = best_cost_q;
    assign best_idx_o  = best_idx_q;

endmodule

/* design/block_buffer.sv */
// Four-row block buffer
`timescale 1ns/1ps
`include "cost_settings.svh"

module block_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   row_capture_i,
    input  cost_types_pkg::row_t   row_data_i,
    output cost_types_pkg::block_t block_o
);

    cost_types_pkg::block_t block_q;

    // --------------------
    // Row shift register
    // New rows enter at the top, so after four captures
    // the first row sits at positions 0 to 3
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block_q <= '0;
        end else if (row_capture_i) begin
            block_q <= {
                row_data_i,
                block_q[`COST_NPOS*`COST_PIXEL_W-1:`COST_BLOCK_SIZE*`COST_PIXEL_W]
            };
        end
    end

    assign block_o = block_q;

endmodule

/* design/cost_ctrl_fsm.sv */
// Cost engine control FSM
`timescale 1ns/1ps

module cost_ctrl_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic row_req_i,
    input  logic row_last_i,
    input  logic res_ack_i,
    input  logic row_full_i,
    input  logic cand_last_i,
    input  logic calc_done_i,
    output logic row_ack_o,
    output logic row_capture_o,
    output logic calc_start_o,
    output logic best_update_o,
    output logic best_clear_o,
    output logic res_req_o
);

    cost_ctrl_pkg::ctrl_state_t state_q;
    cost_ctrl_pkg::ctrl_state_t state_d;
    // Last row of the sequence has been captured
    logic                       seq_end_q;

    // --------------------
    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            cost_ctrl_pkg::IDLE: begin
                if (row_req_i) begin
                    state_d = cost_ctrl_pkg::ROW_ACK;
                end
            end
            cost_ctrl_pkg::ROW_ACK: begin
                if (!row_req_i) begin
                    state_d = cost_ctrl_pkg::ROW_REL;
                end
            end
            cost_ctrl_pkg::ROW_REL: begin
                // Score the block once all four rows are in
                if (row_full_i) begin
                    state_d = cost_ctrl_pkg::CALC;
                end else begin
                    state_d = cost_ctrl_pkg::IDLE;
                end
            end
            cost_ctrl_pkg::CALC: begin
                if (calc_done_i) begin
                    state_d = cost_ctrl_pkg::UPDATE;
                end
            end
            cost_ctrl_pkg::UPDATE: begin
                if (seq_end_q || cand_last_i) begin
                    state_d = cost_ctrl_pkg::RES_REQ;
                end else begin
                    state_d = cost_ctrl_pkg::IDLE;
                end
            end
            cost_ctrl_pkg::RES_REQ: begin
                if (res_ack_i) begin
                    state_d = cost_ctrl_pkg::RES_REL;
                end
            end
            cost_ctrl_pkg::RES_REL: begin
                if (!res_ack_i) begin
                    state_d = cost_ctrl_pkg::IDLE;
                end
            end
            default: begin
                state_d = cost_ctrl_pkg::IDLE;
            end
        endcase
    end

    // --------------------
    // State and sequence end flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= cost_ctrl_pkg::IDLE;
            seq_end_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (best_clear_o) begin
                seq_end_q <= 1'b0;
            end else if (row_capture_o && row_last_i) begin
                seq_end_q <= 1'b1;
            end
        end
    end

    // Outputs decoded from the state register
    assign row_capture_o = (state_q == cost_ctrl_pkg::IDLE) && row_req_i;
    assign row_ack_o     = (state_q == cost_ctrl_pkg::ROW_ACK);
    assign calc_start_o  = (state_q == cost_ctrl_pkg::ROW_REL) && row_full_i;
    assign best_update_o = (state_q == cost_ctrl_pkg::UPDATE);
    assign res_req_o     = (state_q == cost_ctrl_pkg::RES_REQ);
    // Tracker clears once the host has released its ack
    assign best_clear_o  = (state_q == cost_ctrl_pkg::RES_REL) && !res_ack_i;

endmodule

/* design/cost_ctrl_pkg.sv */
// Cost engine control types
package cost_ctrl_pkg;

    // Control FSM states
    typedef enum logic [2:0] {
        IDLE,
        ROW_ACK,
        ROW_REL,
        CALC,
        UPDATE,
        RES_REQ,
        RES_REL
    } ctrl_state_t;

endpackage

/* design/cost_engine_top.sv */
// Block match cost engine
`timescale 1ns/1ps

module cost_engine_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      row_req_i,
    input  cost_types_pkg::row_t      row_data_i,
    input  logic                      row_last_i,
    input  logic                      wgt_we_i,
    input  cost_types_pkg::wgt_addr_t wgt_addr_i,
    input  cost_types_pkg::weight_t   wgt_data_i,
    input  logic                      res_ack_i,
    output logic                      row_ack_o,
    output logic                      res_req_o,
    output cost_types_pkg::cost_t     best_cost_o,
    output cost_types_pkg::cand_idx_t best_idx_o
);

    logic                        row_capture;
    logic                        row_full;
    logic                        cand_last;
    logic                        calc_start;
    logic                        calc_done;
    logic                        best_update;
    logic                        best_clear;
    cost_types_pkg::cand_idx_t   cand_idx;
    cost_types_pkg::cost_t       calc_cost;
    cost_types_pkg::block_t      block;
    cost_types_pkg::weight_vec_t weights;

    // --------------------
    // Control
    cost_ctrl_fsm u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .row_req_i    (row_req_i),
        .row_last_i   (row_last_i),
        .res_ack_i    (res_ack_i),
        .row_full_i   (row_full),
        .cand_last_i  (cand_last),
        .calc_done_i  (calc_done),
        .row_ack_o    (row_ack_o),
        .row_capture_o(row_capture),
        .calc_start_o (calc_start),
        .best_update_o(best_update),
        .best_clear_o (best_clear),
        .res_req_o    (res_req_o)
    );

    seq_counter u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .row_capture_i(row_capture),
        .best_update_i(best_update),
        .best_clear_i (best_clear),
        .row_full_o   (row_full),
        .cand_idx_o   (cand_idx),
        .cand_last_o  (cand_last)
    );

    // --------------------
    // Datapath
    block_buffer u_block (
        .clk          (clk),
        .rst_n        (rst_n),
        .row_capture_i(row_capture),
        .row_data_i   (row_data_i),
        .block_o      (block)
    );

    weight_table u_weights (
        .clk       (clk),
        .rst_n     (rst_n),
        .wgt_we_i  (wgt_we_i),
        .wgt_addr_i(wgt_addr_i),
        .wgt_data_i(wgt_data_i),
        .weights_o (weights)
    );

    hadamard_cost u_cost (
        .clk         (clk),
        .rst_n       (rst_n),
        .calc_start_i(calc_start),
        .block_i     (block),
        .weights_i   (weights),
        .calc_cost_o (calc_cost),
        .calc_done_o (calc_done)
    );

    best_tracker u_best (
        .clk          (clk),
        .rst_n        (rst_n),
        .best_update_i(best_update),
        .best_clear_i (best_clear),
        .calc_cost_i  (calc_cost),
        .cand_idx_i   (cand_idx),
        .best_cost_o  (best_cost_o),
        .best_idx_o   (best_idx_o)
    );

endmodule

/* design/cost_settings.svh */
// Cost engine settings
`ifndef COST_SETTINGS_SVH
`define COST_SETTINGS_SVH

// Block geometry
`define COST_BLOCK_SIZE 4
`define COST_NPOS       16

// --------------------
// Data widths
`define COST_PIXEL_W    8
`define COST_WEIGHT_W   16
`define COST_SUM_W      32
`define COST_IDX_W      4

`endif

/* design/cost_types_pkg.sv */
// Cost engine data types
`include "cost_settings.svh"

package cost_types_pkg;

    // Single pixel, unsigned
    typedef logic [`COST_PIXEL_W-1:0] pixel_t;

    // Pixel c at bits 8c+7..8c
    typedef logic [`COST_BLOCK_SIZE*`COST_PIXEL_W-1:0] row_t;

    // Position 4r+c holds row r, column c
    typedef logic [`COST_NPOS*`COST_PIXEL_W-1:0] block_t;

    // --------------------
    // Weights
    typedef logic signed [`COST_WEIGHT_W-1:0] weight_t;
    typedef logic [`COST_NPOS*`COST_WEIGHT_W-1:0] weight_vec_t;
    typedef logic [$clog2(`COST_NPOS)-1:0] wgt_addr_t;

    // --------------------
    // Results
    typedef logic [`COST_SUM_W-1:0] cost_t;
    typedef logic [`COST_IDX_W-1:0] cand_idx_t;

endpackage

/* design/hadamard_cost.sv */
// Weighted Hadamard cost
`timescale 1ns/1ps
`include "cost_settings.svh"

module hadamard_cost (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        calc_start_i,
    input  cost_types_pkg::block_t      block_i,
    input  cost_types_pkg::weight_vec_t weights_i,
    output cost_types_pkg::cost_t       calc_cost_o,
    output logic                        calc_done_o
);

    cost_types_pkg::pixel_t          pix      [`COST_NPOS];
    logic signed [`COST_PIXEL_W+2:0] row_coef [`COST_NPOS];
    logic signed [`COST_PIXEL_W+4:0] coef     [`COST_NPOS];
    logic signed [`COST_PIXEL_W+4:0] coef_abs [`COST_NPOS];
    logic        [`COST_PIXEL_W+3:0] abs_q    [`COST_NPOS];
    logic signed [`COST_SUM_W-1:0]   prod     [`COST_NPOS];
    logic signed [`COST_SUM_W-1:0]   pair_q   [`COST_NPOS/2];
    cost_types_pkg::cost_t           pair_sum;
    logic [1:0]                      start_dly_q;

    // --------------------
    // Butterflies
    for (genvar r = 0; r < `COST_BLOCK_SIZE; r++) begin : g_bfly
        logic signed [`COST_PIXEL_W+1:0] a0, a1, a2, a3;
        logic signed [`COST_PIXEL_W+3:0] b0, b1, b2, b3;

        assign a0 = $signed({2'b00, pix[4*r+0]}) + $signed({2'b00, pix[4*r+2]});
        assign a1 = $signed({2'b00, pix[4*r+1]}) + $signed({2'b00, pix[4*r+3]});
        assign a2 = $signed({2'b00, pix[4*r+1]}) - $signed({2'b00, pix[4*r+3]});
        assign a3 = $signed({2'b00, pix[4*r+0]}) - $signed({2'b00, pix[4*r+2]});
        assign row_coef[4*r+0] = a0 + a1;
        assign row_coef[4*r+1] = a3 + a2;
        assign row_coef[4*r+2] = a3 - a2;
        assign row_coef[4*r+3] = a0 - a1;

        // Same pattern down column r
        assign b0 = row_coef[r+0] + row_coef[r+8];
        assign b1 = row_coef[r+4] + row_coef[r+12];
        assign b2 = row_coef[r+4] - row_coef[r+12];
        assign b3 = row_coef[r+0] - row_coef[r+8];
        assign coef[r+0]  = b0 + b1;
        assign coef[r+4]  = b3 + b2;
        assign coef[r+8]  = b3 - b2;
        assign coef[r+12] = b0 - b1;
    end

    // Stage 1, absolute coefficients
    for (genvar i = 0; i < `COST_NPOS; i++) begin : g_pos
        assign pix[i]      = block_i[i*`COST_PIXEL_W +: `COST_PIXEL_W];
        assign coef_abs[i] = coef[i][`COST_PIXEL_W+4] ? -coef[i] : coef[i];
        assign prod[i] = {{(`COST_SUM_W-`COST_PIXEL_W-4){1'b0}}, abs_q[i]}
            * {{(`COST_SUM_W-`COST_WEIGHT_W){weights_i[(i+1)*`COST_WEIGHT_W-1]}},
               weights_i[i*`COST_WEIGHT_W +: `COST_WEIGHT_W]};

        always_ff @(posedge clk) begin
            abs_q[i] <= coef_abs[i][`COST_PIXEL_W+3:0];
        end
    end

    // --------------------
    // Stage 2, pairwise products
    always_ff @(posedge clk) begin
        for (int k = 0; k < `COST_NPOS/2; k++) begin
            pair_q[k] <= prod[2*k] + prod[2*k+1];
        end
    end

    // Stage 3 sum, wraps modulo 2^32
    always_comb begin
        pair_sum = '0;
        for (int k = 0; k < `COST_NPOS/2; k++) begin
            pair_sum = pair_sum + pair_q[k];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_dly_q <= '0;
            calc_done_o <= 1'b0;
            calc_cost_o <= '0;
        end else begin
            start_dly_q <= {start_dly_q[0], calc_start_i};
            calc_done_o <= start_dly_q[1];
            // Result held until the next block
            if (start_dly_q[1]) begin
                calc_cost_o <= pair_sum;
            end
        end
    end

endmodule

/* design/seq_counter.sv */
// Row and candidate counters
`timescale 1ns/1ps
`include "cost_settings.svh"

module seq_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     row_capture_i,
    input  logic                     best_update_i,
    input  logic                     best_clear_i,
    output logic                     row_full_o,
    output cost_types_pkg::cand_idx_t cand_idx_o,
    output logic                     cand_last_o
);

    logic [1:0]                row_cnt_q;
    logic                      row_full_q;
    cost_types_pkg::cand_idx_t cand_idx_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt_q  <= '0;
            row_full_q <= 1'b0;
            cand_idx_q <= '0;
        end else if (best_clear_i) begin
            row_cnt_q  <= '0;
            row_full_q <= 1'b0;
            cand_idx_q <= '0;
        end else begin
            // Row count wraps after the fourth row
            if (row_capture_i) begin
                row_cnt_q <= row_cnt_q + 2'd1;
                if (row_cnt_q == 2'(`COST_BLOCK_SIZE - 1)) begin
                    row_full_q <= 1'b1;
                end
            end
            // Scored block is consumed by the update
            if (best_update_i) begin
                row_full_q <= 1'b0;
                cand_idx_q <= cand_idx_q + 1'b1;
            end
        end
    end

    assign row_full_o  = row_full_q;
    assign cand_idx_o  = cand_idx_q;
    assign cand_last_o = (cand_idx_q == '1);

endmodule

/* design/weight_table.sv */
// Position weight table
`timescale 1ns/1ps
`include "cost_settings.svh"

module weight_table (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wgt_we_i,
    input  cost_types_pkg::wgt_addr_t   wgt_addr_i,
    input  cost_types_pkg::weight_t     wgt_data_i,
    output cost_types_pkg::weight_vec_t weights_o
);

    cost_types_pkg::weight_t weights_q [`COST_NPOS];

    // Unit weights give plain SATD
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `COST_NPOS; i++) begin
                weights_q[i] <= cost_types_pkg::weight_t'(1);
            end
        end else if (wgt_we_i) begin
            weights_q[wgt_addr_i] <= wgt_data_i;
        end
    end

    // Flatten in block position order
    always_comb begin
        for (int i = 0; i < `COST_NPOS; i++) begin
            weights_o[i*`COST_WEIGHT_W +: `COST_WEIGHT_W] = weights_q[i];
        end
    end

endmodule

/* dv/cost_engine_properties.sv */
// Cost engine handshake assertions
`timescale 1ns/1ps

module cost_engine_props (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      row_req_i,
    input logic                      row_ack_i,
    input logic                      res_req_i,
    input logic                      res_ack_i,
    input logic                      calc_start_i,
    input logic                      calc_done_i,
    input cost_types_pkg::cost_t     best_cost_i,
    input cost_types_pkg::cand_idx_t best_idx_i
);

    // Read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // --------------------
    // Row handshake
    row_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(row_ack_i) |-> row_req_i
    ) else begin
        fail_count++;
        $error("row_ack_o rose while row_req_i was low");
    end

    // --------------------
    // Result handshake
    res_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        res_req_i && !res_ack_i |=> res_req_i
    ) else begin
        fail_count++;
        $error("res_req_o dropped before res_ack_i");
    end

    res_data_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        res_req_i |=> $stable(best_cost_i) && $stable(best_idx_i)
    ) else begin
        fail_count++;
        $error("best_cost_o or best_idx_o changed while res_req_o was high");
    end

    // Control outputs quiet in reset
    reset_quiet: assert property (
        @(posedge clk)
        !rst_n |-> !row_ack_i && !res_req_i && !calc_start_i && !calc_done_i
    ) else begin
        fail_count++;
        $error("control output high during reset");
    end

endmodule

bind cost_engine_top cost_engine_props i_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .row_req_i   (row_req_i),
    .row_ack_i   (row_ack_o),
    .res_req_i   (res_req_o),
    .res_ack_i   (res_ack_i),
    .calc_start_i(calc_start),
    .calc_done_i (calc_done),
    .best_cost_i (best_cost_o),
    .best_idx_i  (best_idx_o)
);

/* dv/cost_engine_tb.sv */
// Cost engine testbench
`timescale 1ns/1ps
`include "cost_settings.svh"

module cost_engine_tb;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int MAX_CANDS      = 1 << `COST_IDX_W;

    logic                        clk;
    logic                        rst_n;
    logic                        row_req_i;
    cost_types_pkg::row_t        row_data_i;
    logic                        row_last_i;
    logic                        wgt_we_i;
    cost_types_pkg::wgt_addr_t   wgt_addr_i;
    cost_types_pkg::weight_t     wgt_data_i;
    logic                        res_ack_i;
    logic                        row_ack_o;
    logic                        res_req_o;
    cost_types_pkg::cost_t       best_cost_o;
    cost_types_pkg::cand_idx_t   best_idx_o;

    logic [31:0]                 lfsr_q;
    // Mirror of the weight table
    cost_types_pkg::weight_t     model_weight [`COST_NPOS];
    cost_types_pkg::block_t      cand_blocks  [MAX_CANDS];

    cost_engine_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_req_i  (row_req_i),
        .row_data_i (row_data_i),
        .row_last_i (row_last_i),
        .wgt_we_i   (wgt_we_i),
        .wgt_addr_i (wgt_addr_i),
        .wgt_data_i (wgt_data_i),
        .res_ack_i  (res_ack_i),
        .row_ack_o  (row_ack_o),
        .res_req_o  (res_req_o),
        .best_cost_o(best_cost_o),
        .best_idx_o (best_idx_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic cost_types_pkg::block_t random_block();
        cost_types_pkg::block_t b;
        for (int i = 0; i < `COST_NPOS; i++) begin
            b[i*`COST_PIXEL_W +: `COST_PIXEL_W] =
                cost_types_pkg::pixel_t'(rand_bits(`COST_PIXEL_W));
        end
        return b;
    endfunction

    // --------------------
    // Reference cost model
    function automatic cost_types_pkg::cost_t model_cost(input cost_types_pkg::block_t blk);
        int p [`COST_NPOS];
        int t [`COST_NPOS];
        int h [`COST_NPOS];
        int a0, a1, a2, a3;
        int mag;
        cost_types_pkg::cost_t sum;
        for (int i = 0; i < `COST_NPOS; i++) begin
            p[i] = int'(blk[i*`COST_PIXEL_W +: `COST_PIXEL_W]);
        end
        // Rows first
        for (int r = 0; r < `COST_BLOCK_SIZE; r++) begin
            a0 = p[4*r] + p[4*r+2];
            a1 = p[4*r+1] + p[4*r+3];
            a2 = p[4*r+1] - p[4*r+3];
            a3 = p[4*r] - p[4*r+2];
            t[4*r]   = a0 + a1;
            t[4*r+1] = a3 + a2;
            t[4*r+2] = a3 - a2;
            t[4*r+3] = a0 - a1;
        end
        // Then down each column
        for (int c = 0; c < `COST_BLOCK_SIZE; c++) begin
            a0 = t[c] + t[c+8];
            a1 = t[c+4] + t[c+12];
            a2 = t[c+4] - t[c+12];
            a3 = t[c] - t[c+8];
            h[c]    = a0 + a1;
            h[c+4]  = a3 + a2;
            h[c+8]  = a3 - a2;
            h[c+12] = a0 - a1;
        end
        sum = '0;
        for (int i = 0; i < `COST_NPOS; i++) begin
            mag = (h[i] < 0) ? -h[i] : h[i];
            sum = sum + cost_types_pkg::cost_t'(mag * int'(model_weight[i]));
        end
        return sum;
    endfunction

    // --------------------
    // Failure and compare
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_cost(input string name, input cost_types_pkg::cost_t got,
                              input cost_types_pkg::cost_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s is 0x%08h, expected 0x%08h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_idx(input string name, input cost_types_pkg::cand_idx_t got,
                             input cost_types_pkg::cand_idx_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    // --------------------
    // Bus drivers
    task automatic write_weight(input cost_types_pkg::wgt_addr_t addr,
                                input cost_types_pkg::weight_t data);
        @(posedge clk);
        wgt_we_i   <= 1'b1;
        wgt_addr_i <= addr;
        wgt_data_i <= data;
        model_weight[addr] = data;
        @(posedge clk);
        wgt_we_i <= 1'b0;
    endtask

    task automatic send_row(input cost_types_pkg::row_t data, input logic last);
        int n;
        @(posedge clk);
        row_req_i  <= 1'b1;
        row_data_i <= data;
        row_last_i <= last;
        n = 0;
        @(negedge clk);
        while (!row_ack_o && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!row_ack_o) begin
            abort_run("timeout waiting for row_ack_o to rise");
        end
        @(posedge clk);
        row_req_i  <= 1'b0;
        row_last_i <= 1'b0;
        n = 0;
        @(negedge clk);
        while (row_ack_o && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (row_ack_o) begin
            abort_run("timeout waiting for row_ack_o to fall");
        end
    endtask

    task automatic send_block(input cost_types_pkg::block_t blk, input logic last);
        for (int r = 0; r < `COST_BLOCK_SIZE; r++) begin
            send_row(blk[r*`COST_BLOCK_SIZE*`COST_PIXEL_W +: `COST_BLOCK_SIZE*`COST_PIXEL_W],
                     last && (r == `COST_BLOCK_SIZE - 1));
        end
    endtask

    // Withholds the ack for hold cycles while watching the result
    task automatic get_result(output cost_types_pkg::cost_t cost,
                              output cost_types_pkg::cand_idx_t idx, input int hold);
        int n;
        n = 0;
        @(negedge clk);
        while (!res_req_o && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!res_req_o) begin
            abort_run("timeout waiting for res_req_o to rise");
        end
        cost = best_cost_o;
        idx  = best_idx_o;
        for (int k = 0; k < hold; k++) begin
            @(negedge clk);
            if (!res_req_o) begin
                abort_run("res_req_o dropped while res_ack_i was withheld");
            end
            check_cost("best_cost_o", best_cost_o, cost);
            check_idx("best_idx_o", best_idx_o, idx);
        end
        @(posedge clk);
        res_ack_i <= 1'b1;
        n = 0;
        @(negedge clk);
        while (res_req_o && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (res_req_o) begin
            abort_run("timeout waiting for res_req_o to fall");
        end
        @(posedge clk);
        res_ack_i <= 1'b0;
    endtask

    // Scores cand_blocks[0..count-1] as one sequence
    task automatic run_sequence(input int count, input logic mark_last, input int hold);
        cost_types_pkg::cost_t     exp_cost;
        cost_types_pkg::cand_idx_t exp_idx;
        cost_types_pkg::cost_t     got_cost;
        cost_types_pkg::cand_idx_t got_idx;
        cost_types_pkg::cost_t     c;
        exp_cost = '0;
        exp_idx  = '0;
        for (int i = 0; i < count; i++) begin
            c = model_cost(cand_blocks[i]);
            if (i == 0 || c < exp_cost) begin
                exp_cost = c;
                exp_idx  = cost_types_pkg::cand_idx_t'(i);
            end
            send_block(cand_blocks[i], mark_last && (i == count - 1));
        end
        get_result(got_cost, got_idx, hold);
        check_cost("best_cost_o", got_cost, exp_cost);
        check_idx("best_idx_o", got_idx, exp_idx);
    endtask

    // --------------------
    // Directed tests
    task automatic default_weight_satd();
        cost_types_pkg::block_t blk;
        cand_blocks[0] = {`COST_NPOS{8'd100}};
        run_sequence(1, 1'b1, 0);
        for (int r = 0; r < `COST_BLOCK_SIZE; r++) begin
            for (int c = 0; c < `COST_BLOCK_SIZE; c++) begin
                blk[(4*r+c)*`COST_PIXEL_W +: `COST_PIXEL_W] = ((r + c) % 2 == 0) ? 8'd200 : 8'd0;
            end
        end
        cand_blocks[0] = blk;
        run_sequence(1, 1'b1, 0);
    endtask

    task automatic weighted_cost_wrap();
        // All negative weights force the sum to wrap
        for (int i = 0; i < `COST_NPOS; i++) begin
            write_weight(cost_types_pkg::wgt_addr_t'(i), cost_types_pkg::weight_t'(-1));
        end
        cand_blocks[0] = random_block();
        run_sequence(1, 1'b1, 0);
        for (int i = 0; i < `COST_NPOS; i++) begin
            write_weight(cost_types_pkg::wgt_addr_t'(i),
                         cost_types_pkg::weight_t'(rand_bits(`COST_WEIGHT_W)));
        end
        cand_blocks[0] = random_block();
        run_sequence(1, 1'b1, 0);
    endtask

    task automatic min_tracking();
        cost_types_pkg::cost_t c;
        cost_types_pkg::cost_t low;
        int                    m;
        for (int i = 0; i < 7; i++) begin
            cand_blocks[i] = random_block();
        end
        m   = 0;
        low = model_cost(cand_blocks[0]);
        for (int i = 1; i < 7; i++) begin
            c = model_cost(cand_blocks[i]);
            if (c < low) begin
                low = c;
                m   = i;
            end
        end
        // Repeat of the minimum, so the earlier index must win
        cand_blocks[7] = cand_blocks[m];
        run_sequence(8, 1'b1, 0);
    endtask

    task automatic sixteen_candidates();
        for (int i = 0; i < MAX_CANDS; i++) begin
            cand_blocks[i] = random_block();
        end
        run_sequence(MAX_CANDS, 1'b0, 0);
    endtask

    task automatic result_backpressure();
        cost_types_pkg::block_t lo;
        cost_types_pkg::block_t hi;
        cost_types_pkg::block_t tmp;
        lo = random_block();
        hi = random_block();
        if (model_cost(hi) < model_cost(lo)) begin
            tmp = lo;
            lo  = hi;
            hi  = tmp;
        end
        cand_blocks[0] = hi;
        cand_blocks[1] = lo;
        run_sequence(2, 1'b1, 40);
        // A stale best would report the lower cost here
        cand_blocks[0] = hi;
        run_sequence(1, 1'b1, 0);
    endtask

    // --------------------
    // Main sequence
    initial begin
        rst_n      = 1'b0;
        row_req_i  = 1'b0;
        row_data_i = '0;
        row_last_i = 1'b0;
        wgt_we_i   = 1'b0;
        wgt_addr_i = '0;
        wgt_data_i = '0;
        res_ack_i  = 1'b0;
        lfsr_q     = 32'h1d28_7340;
        for (int i = 0; i < `COST_NPOS; i++) begin
            model_weight[i] = cost_types_pkg::weight_t'(1);
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        default_weight_satd();
        weighted_cost_wrap();
        min_tracking();
        sixteen_candidates();
        result_backpressure();

        repeat (4) @(posedge clk);
        if (i_dut.i_props.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("assertion failures were reported on the DUT handshakes");
        end
    end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module cost_engine_tb -Mdir obj_dir -f compile.f \
    && {
        sim_out=$(./obj_dir/Vcost_engine_tb +verilator+error+limit+1000)
        printf '%s\n' "$sim_out"
        printf '%s\n' "$sim_out" | grep -qx '>>> PASS'
    } \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
